// ==== hdl/cdc_fifo_settings.svh ====
// Build-time sizing of the dual-clock FIFO
// Depth, entry width, address width and synchronizer length
`ifndef CDC_FIFO_SETTINGS_SVH
`define CDC_FIFO_SETTINGS_SVH

// ---------------------------------------------------------------------
// Storage geometry
// ---------------------------------------------------------------------

// Number of entries; the pointer arithmetic relies on a power of two
`define CDC_FIFO_DEPTH 8
// Bits carried by one entry
`define CDC_FIFO_WIDTH 16
// Must stay equal to log2 of the depth
`define CDC_FIFO_ADDR_WIDTH 3

// ---------------------------------------------------------------------
// Clock crossing
// ---------------------------------------------------------------------

// Destination flops in each gray count synchronizer
`define CDC_FIFO_SYNC_STAGES 3

`endif

// ==== hdl/fifo_ptr_pkg.sv ====
// FIFO pointer types: address, count and the two-way pointer union
// Binary and gray code conversion on counts
`include "cdc_fifo_settings.svh"
`default_nettype none

package fifo_ptr_pkg;

  typedef logic [`CDC_FIFO_ADDR_WIDTH-1:0] addr_t;
  // One extra bit so a full FIFO and an empty FIFO read differently
  typedef logic [`CDC_FIFO_ADDR_WIDTH:0] count_t;

  // The same pointer word is used as a count for occupancy math and
  // as a wrap bit over a RAM address for the storage port
  typedef union packed {
    count_t count;
    struct packed {
      logic  wrap;
      addr_t addr;
    } field;
  } ptr_u;

  function automatic count_t bin_to_gray(input count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all gray bits at or above it
  function automatic count_t gray_to_bin(input count_t gray);
    count_t bin;
    bin[$bits(count_t)-1] = gray[$bits(count_t)-1];
    for (int i = $bits(count_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/fifo_flow_pkg.sv ====
// Data flow types of the dual-clock FIFO
// Entry payload and credit count
`include "cdc_fifo_settings.svh"
`default_nettype none

package fifo_flow_pkg;

  // One payload word as pushed and popped
  typedef logic [`CDC_FIFO_WIDTH-1:0] entry_t;

  // Credits never exceed the depth, so this matches the pointer count width
  typedef logic [`CDC_FIFO_ADDR_WIDTH:0] credit_t;

endpackage

`default_nettype wire

// ==== hdl/cdc_gray_count_sync.sv ====
// Gray count crossing from a source clock into a destination clock
// Source register followed by a chain of destination flops
`include "cdc_fifo_settings.svh"
`default_nettype none

module cdc_gray_count_sync
  import fifo_ptr_pkg::*;
(
  input  logic   src_clk,
  input  logic   src_reset,
  input  count_t src_count_gray,
  input  logic   dst_clk,
  input  logic   dst_reset,
  output count_t dst_count_gray
);

  // Launch flop, so only a clean register output crosses the boundary
  count_t src_count_q;
  // Index 0 samples the asynchronous value and may go metastable
  count_t [`CDC_FIFO_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge src_clk) begin
    if (src_reset) begin
      src_count_q <= '0;
    end else begin
      src_count_q <= src_count_gray;
    end
  end

  always_ff @(posedge dst_clk) begin
    if (dst_reset) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`CDC_FIFO_SYNC_STAGES-2:0], src_count_q};
    end
  end

  assign dst_count_gray = sync_q[`CDC_FIFO_SYNC_STAGES-1];

  // A multi-bit gray step could be sampled as a value never held by the source
  gray_single_step_a : assert property (@(posedge src_clk) disable iff (src_reset)
    $onehot0(src_count_gray ^ src_count_q));

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_push_ctrl.sv ====
// Push-side controller of the dual-clock FIFO
// Write pointer, slot count, credit counter and the RAM write port
`include "cdc_fifo_settings.svh"
`default_nettype none

module cdc_fifo_push_ctrl
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,
  input  entry_t  push_data,
  input  credit_t credit_withhold_push,
  output credit_t credit_count_push,
  output credit_t credit_available_push,
  output logic    push_full,
  output count_t  push_slots,
  output logic    ram_wr_valid,
  output addr_t   ram_wr_addr,
  output entry_t  ram_wr_data,
  output count_t  push_count_gray,
  input  count_t  pop_count_gray
);

  localparam count_t depth_count = count_t'(`CDC_FIFO_DEPTH);
  localparam credit_t depth_credit = credit_t'(`CDC_FIFO_DEPTH);

  ptr_u    wr_ptr;
  count_t  wr_count_next;
  count_t  pop_count_bin;
  count_t  pop_count_seen;
  credit_t credit_returned;
  credit_t credit_count_next;
  logic    credit_enable;

  // ---------------------------------------------------------------------
  // Write pointer and RAM write port
  // ---------------------------------------------------------------------

  // Every accepted push goes straight to the RAM in the same cycle
  assign ram_wr_valid  = push_valid;
  assign ram_wr_addr   = wr_ptr.field.addr;
  assign ram_wr_data   = push_data;
  assign wr_count_next = wr_ptr.count + count_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr.count    <= '0;
      push_count_gray <= '0;
    end else if (push_valid) begin
      wr_ptr.count <= wr_count_next;
      // Gray copy moves with the pointer so the pop side never sees a half-step
      push_count_gray <= bin_to_gray(wr_count_next);
    end
  end

  // ---------------------------------------------------------------------
  // Slot accounting
  // ---------------------------------------------------------------------

  assign pop_count_bin = gray_to_bin(pop_count_gray);

  // The pop count lags, so slots read low and never overstate free space
  assign push_slots = depth_count - (wr_ptr.count - pop_count_bin);
  assign push_full  = (push_slots == '0);

  // ---------------------------------------------------------------------
  // Credit counter
  // ---------------------------------------------------------------------

  // Pop steps that arrived since last cycle, modulo the count width
  assign credit_returned = credit_t'(pop_count_bin - pop_count_seen);

  assign credit_count_next = credit_count_push - credit_t'(push_credit) + credit_returned;

  always_ff @(posedge clk) begin
    if (reset) begin
      pop_count_seen    <= '0;
      credit_count_push <= depth_credit;
      credit_enable     <= 1'b0;
    end else begin
      pop_count_seen    <= pop_count_bin;
      credit_count_push <= credit_count_next;
      // Credit return starts on the first cycle out of reset
      credit_enable     <= 1'b1;
    end
  end

  // Withheld credits stay in the counter and are simply not offered
  assign credit_available_push = (credit_count_push > credit_withhold_push) ?
                                 credit_count_push - credit_withhold_push : '0;

  // At most one credit per cycle goes back to the sender
  assign push_credit = credit_enable && !push_credit_stall &&
                       (credit_available_push != '0);

  // A sender that honors its credits can never push into a full FIFO
  no_push_when_full_a : assert property (@(posedge clk) disable iff (reset)
    push_valid |-> !push_full);

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_pop_ctrl.sv ====
// Pop-side controller of the dual-clock FIFO
// Read pointers, item count, RAM read issue and the two-entry output stage
`default_nettype none

module cdc_fifo_pop_ctrl
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   pop_ready,
  output logic   pop_valid,
  output entry_t pop_data,
  output logic   pop_empty,
  output count_t pop_items,
  output logic   ram_rd_addr_valid,
  output addr_t  ram_rd_addr,
  input  logic   ram_rd_data_valid,
  input  entry_t ram_rd_data,
  input  count_t push_count_gray,
  output count_t pop_count_gray
);

  ptr_u       rd_ptr;
  count_t     pop_ptr;
  count_t     pop_ptr_next;
  count_t     push_count_bin;
  logic       unread;
  logic       pop_fire;
  logic       shift;
  logic       bypass_pop;
  logic       store;
  logic [1:0] stage_count;
  logic [1:0] stage_count_next;
  logic [1:0] kept_count;
  entry_t     stage_data0;
  entry_t     stage_data1;

  // ---------------------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------------------

  assign push_count_bin = gray_to_bin(push_count_gray);

  // Items still belong to the FIFO until they leave through the pop port
  assign pop_items = push_count_bin - pop_ptr;
  assign pop_empty = (pop_items == '0);
  assign unread    = (push_count_bin != rd_ptr.count);

  // ---------------------------------------------------------------------
  // Output stage
  // ---------------------------------------------------------------------

  // The head is the oldest stored entry, or returning RAM data if none is held
  assign pop_valid = (stage_count != 2'd0) || ram_rd_data_valid;
  assign pop_data  = (stage_count != 2'd0) ? stage_data0 : ram_rd_data;
  assign pop_fire  = pop_valid && pop_ready;

  // Stored head leaves; or returning data passes straight through
  assign shift      = pop_fire && (stage_count != 2'd0);
  assign bypass_pop = pop_fire && (stage_count == 2'd0);
  assign kept_count = stage_count - 2'(shift);
  assign store      = ram_rd_data_valid && !bypass_pop;

  assign stage_count_next = stage_count + 2'(ram_rd_data_valid) - 2'(pop_fire);

  // A read issued now returns next cycle, so one place must remain even
  // if nothing is popped then
  assign ram_rd_addr_valid = unread && (stage_count_next < 2'd2);
  assign ram_rd_addr       = rd_ptr.field.addr;

  always_ff @(posedge clk) begin
    if (store && (kept_count == 2'd0)) begin
      stage_data0 <= ram_rd_data;
    end else if (shift) begin
      stage_data0 <= stage_data1;
    end
    if (store && (kept_count == 2'd1)) begin
      stage_data1 <= ram_rd_data;
    end
  end

  // ---------------------------------------------------------------------
  // Control registers
  // ---------------------------------------------------------------------

  assign pop_ptr_next = pop_ptr + count_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr.count   <= '0;
      pop_ptr        <= '0;
      pop_count_gray <= '0;
      stage_count    <= 2'd0;
    end else begin
      stage_count <= stage_count_next;
      if (ram_rd_addr_valid) begin
        rd_ptr.count <= rd_ptr.count + count_t'(1);
      end
      // The slot is handed back only once its data has left the stage
      if (pop_fire) begin
        pop_ptr        <= pop_ptr_next;
        pop_count_gray <= bin_to_gray(pop_ptr_next);
      end
    end
  end

  // The RAM must answer exactly one cycle after each read request
  rd_latency_a : assert property (@(posedge clk) disable iff (reset)
    ram_rd_data_valid |-> $past(ram_rd_addr_valid));

  no_pop_valid_when_empty_a : assert property (@(posedge clk) disable iff (reset)
    pop_empty |-> !pop_valid);

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_ctrl.sv ====
// Dual-clock FIFO controller without storage
// Push and pop controllers joined by two gray count synchronizers
`default_nettype none

module cdc_fifo_ctrl
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
(
  input  logic    push_clk,
  input  logic    push_reset,
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,
  input  entry_t  push_data,
  input  credit_t credit_withhold_push,
  output credit_t credit_count_push,
  output credit_t credit_available_push,
  output logic    push_full,
  output count_t  push_slots,
  output logic    ram_wr_valid,
  output addr_t   ram_wr_addr,
  output entry_t  ram_wr_data,
  input  logic    pop_clk,
  input  logic    pop_reset,
  input  logic    pop_ready,
  output logic    pop_valid,
  output entry_t  pop_data,
  output logic    pop_empty,
  output count_t  pop_items,
  output logic    ram_rd_addr_valid,
  output addr_t   ram_rd_addr,
  input  logic    ram_rd_data_valid,
  input  entry_t  ram_rd_data
);

  // Prefix names the clock domain the count is seen in
  count_t push_push_count_gray;
  count_t pop_push_count_gray;
  count_t pop_pop_count_gray;
  count_t push_pop_count_gray;

  cdc_fifo_push_ctrl push_ctrl (
    .clk                  (push_clk),
    .reset                (push_reset),
    .push_credit_stall    (push_credit_stall),
    .push_credit          (push_credit),
    .push_valid           (push_valid),
    .push_data            (push_data),
    .credit_withhold_push (credit_withhold_push),
    .credit_count_push    (credit_count_push),
    .credit_available_push(credit_available_push),
    .push_full            (push_full),
    .push_slots           (push_slots),
    .ram_wr_valid         (ram_wr_valid),
    .ram_wr_addr          (ram_wr_addr),
    .ram_wr_data          (ram_wr_data),
    .push_count_gray      (push_push_count_gray),
    .pop_count_gray       (push_pop_count_gray)
  );

  // Write progress tells the pop side that new entries are readable
  cdc_gray_count_sync sync_push_to_pop (
    .src_clk       (push_clk),
    .src_reset     (push_reset),
    .src_count_gray(push_push_count_gray),
    .dst_clk       (pop_clk),
    .dst_reset     (pop_reset),
    .dst_count_gray(pop_push_count_gray)
  );

  // Pop progress frees slots and turns into returned credits
  cdc_gray_count_sync sync_pop_to_push (
    .src_clk       (pop_clk),
    .src_reset     (pop_reset),
    .src_count_gray(pop_pop_count_gray),
    .dst_clk       (push_clk),
    .dst_reset     (push_reset),
    .dst_count_gray(push_pop_count_gray)
  );

  cdc_fifo_pop_ctrl pop_ctrl (
    .clk              (pop_clk),
    .reset            (pop_reset),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items),
    .ram_rd_addr_valid(ram_rd_addr_valid),
    .ram_rd_addr      (ram_rd_addr),
    .ram_rd_data_valid(ram_rd_data_valid),
    .ram_rd_data      (ram_rd_data),
    .push_count_gray  (pop_push_count_gray),
    .pop_count_gray   (pop_pop_count_gray)
  );

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_ram.sv ====
// Flop-based 1R1W storage for the dual-clock FIFO
// Write on the push clock, registered read on the pop clock
`include "cdc_fifo_settings.svh"
`default_nettype none

module cdc_fifo_ram
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
(
  input  logic   wr_clk,
  input  logic   wr_valid,
  input  addr_t  wr_addr,
  input  entry_t wr_data,
  input  logic   rd_clk,
  input  logic   rd_reset,
  input  logic   rd_addr_valid,
  input  addr_t  rd_addr,
  output logic   rd_data_valid,
  output entry_t rd_data
);

  entry_t mem [`CDC_FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The pop side only addresses entries whose write has long settled
  always_ff @(posedge rd_clk) begin
    if (rd_addr_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_addr_valid;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo.sv ====
// Dual-clock FIFO top level
// Controller paired with its flop RAM
`default_nettype none

module cdc_fifo
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
(
  input  logic    push_clk,
  input  logic    push_reset,
  input  logic    push_credit_stall,
  output logic    push_credit,
  input  logic    push_valid,
  input  entry_t  push_data,
  input  credit_t credit_withhold_push,
  output credit_t credit_count_push,
  output credit_t credit_available_push,
  output logic    push_full,
  output count_t  push_slots,
  input  logic    pop_clk,
  input  logic    pop_reset,
  input  logic    pop_ready,
  output logic    pop_valid,
  output entry_t  pop_data,
  output logic    pop_empty,
  output count_t  pop_items
);

  logic   ram_wr_valid;
  addr_t  ram_wr_addr;
  entry_t ram_wr_data;
  logic   ram_rd_addr_valid;
  addr_t  ram_rd_addr;
  logic   ram_rd_data_valid;
  entry_t ram_rd_data;

  cdc_fifo_ctrl ctrl (
    .push_clk, .push_reset, .push_credit_stall, .push_credit, .push_valid,
    .push_data, .credit_withhold_push, .credit_count_push, .credit_available_push,
    .push_full, .push_slots, .ram_wr_valid, .ram_wr_addr, .ram_wr_data,
    .pop_clk, .pop_reset, .pop_ready, .pop_valid, .pop_data, .pop_empty, .pop_items,
    .ram_rd_addr_valid, .ram_rd_addr, .ram_rd_data_valid, .ram_rd_data
  );

  cdc_fifo_ram ram (
    .wr_clk       (push_clk),
    .wr_valid     (ram_wr_valid),
    .wr_addr      (ram_wr_addr),
    .wr_data      (ram_wr_data),
    .rd_clk       (pop_clk),
    .rd_reset     (pop_reset),
    .rd_addr_valid(ram_rd_addr_valid),
    .rd_addr      (ram_rd_addr),
    .rd_data_valid(ram_rd_data_valid),
    .rd_data      (ram_rd_data)
  );

endmodule

`default_nettype wire

// ==== verif/cdc_fifo_tb.sv ====
// Testbench for the dual-clock FIFO
// Credit-honoring random sender, random-ready receiver and a queue model
`include "cdc_fifo_settings.svh"
`default_nettype none

module cdc_fifo_tb
  import fifo_ptr_pkg::*, fifo_flow_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int fifo_depth = `CDC_FIFO_DEPTH;

  logic    push_clk;
  logic    push_reset;
  logic    push_credit_stall;
  logic    push_credit;
  logic    push_valid;
  entry_t  push_data;
  credit_t credit_withhold_push;
  credit_t credit_count_push;
  credit_t credit_available_push;
  logic    push_full;
  count_t  push_slots;
  logic    pop_clk;
  logic    pop_reset;
  logic    pop_ready;
  logic    pop_valid;
  entry_t  pop_data;
  logic    pop_empty;
  count_t  pop_items;

  // Model state shared by the monitors and the main sequence
  entry_t  model_q[$];
  int      credits_held;
  int      pushes;
  int      pops;
  int      credit_sum;
  logic    hold_pending;
  entry_t  held_data;
  entry_t  expected_data;
  // Phase controls, picked up by the drivers at their next drive point
  logic    sender_on;
  logic    stall_random;
  logic    ready_all;
  int      withhold_target;

  cdc_fifo UUT (.*);

  // ---------------------------------------------------------------------
  // Clocks; pop edges sit 30 ns after push edges
  // ---------------------------------------------------------------------

  always #50 push_clk = ~push_clk;

  always begin
    #30;
    pop_clk = ~pop_clk;
    #20;
  end

  // ---------------------------------------------------------------------
  // Checking and failure reporting
  // ---------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic wait_credits(input int target, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge push_clk);
      cycles++;
    end while (credits_held != target && cycles < limit);
    if (credits_held != target) begin
      report_failure("timeout while the sender waited for its credits to return");
    end
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge pop_clk);
      cycles++;
    end while (model_q.size() != 0 && cycles < limit);
    if (model_q.size() != 0) begin
      report_failure("timeout while waiting for the FIFO to drain");
    end
  endtask

  // Stop sending, pop everything and check the idle state with withhold w
  task automatic drain_and_check(input int w);
    sender_on    = 1'b0;
    stall_random = 1'b0;
    ready_all    = 1'b1;
    wait_drain(2000);
    wait_credits(fifo_depth - w, 500);
    // Long enough for both gray counts to settle through the synchronizers
    repeat (30) @(negedge push_clk);
    check_value("pops", pushes, pops);
    check_value("sender credits", fifo_depth - w, credits_held);
    check_value("credit_count_push", w, credit_count_push);
    check_value("credit_available_push", 0, credit_available_push);
    check_value("credit sum", fifo_depth, credits_held + model_q.size() + credit_count_push);
    check_value("push_slots", fifo_depth, push_slots);
    check_value("push_full", 0, push_full);
    @(negedge pop_clk);
    check_value("pop_empty", 1, pop_empty);
    check_value("pop_items", 0, pop_items);
    check_value("pop_valid", 0, pop_valid);
    ready_all = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // Drivers, 10 ns after each rising edge
  // ---------------------------------------------------------------------

  always @(posedge push_clk) begin
    #10;
    // The sender only pushes while it holds a credit
    if (sender_on && credits_held > 0 && $urandom_range(99) < 60) begin
      push_valid = 1'b1;
      push_data  = entry_t'($urandom);
    end else begin
      push_valid = 1'b0;
    end
    push_credit_stall    = stall_random ? ($urandom_range(99) < 30) : 1'b0;
    credit_withhold_push = credit_t'(withhold_target);
  end

  always @(posedge pop_clk) begin
    #10;
    pop_ready = ready_all ? 1'b1 : ($urandom_range(99) < 50);
  end

  // ---------------------------------------------------------------------
  // Monitors, sampling at the falling edge where both domains are stable
  // ---------------------------------------------------------------------

  always @(negedge push_clk) begin
    if (!push_reset) begin
      // Sum taken before this cycle's transfers, so it matches the registered count
      credit_sum = credits_held + model_q.size() + credit_count_push;
      if (credit_sum > fifo_depth) begin
        check_value("credit sum", fifo_depth, credit_sum);
      end
      if (push_credit_stall) begin
        check_value("push_credit", 0, push_credit);
      end
      if (push_valid) begin
        model_q.push_back(push_data);
        credits_held--;
        pushes++;
      end
      if (push_credit) begin
        credits_held++;
      end
    end
  end

  always @(negedge pop_clk) begin
    if (pop_reset) begin
      hold_pending = 1'b0;
    end else begin
      // A stalled item must still be offered with the same data
      if (hold_pending) begin
        check_value("pop_valid", 1, pop_valid);
        check_value("pop_data", held_data, pop_data);
      end
      hold_pending = pop_valid && !pop_ready;
      held_data    = pop_data;
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          report_failure("pop transfer seen while the model holds no item");
        end else begin
          expected_data = model_q.pop_front();
          check_value("pop_data", expected_data, pop_data);
          pops++;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin
    void'($urandom(32'h582f));
    push_clk             = 1'b0;
    pop_clk              = 1'b1;
    push_reset           = 1'b1;
    pop_reset            = 1'b1;
    push_valid           = 1'b0;
    push_data            = '0;
    push_credit_stall    = 1'b0;
    credit_withhold_push = '0;
    pop_ready            = 1'b0;
    credits_held         = 0;
    pushes               = 0;
    pops                 = 0;
    hold_pending         = 1'b0;
    sender_on            = 1'b0;
    stall_random         = 1'b0;
    ready_all            = 1'b0;
    withhold_target      = 0;

    // Both resets start together and each lasts two of its own cycles
    @(negedge push_clk);
    check_value("push_credit", 0, push_credit);
    @(negedge pop_clk);
    check_value("pop_valid", 0, pop_valid);
    @(posedge push_clk);
    #10 push_reset = 1'b0;
    @(posedge pop_clk);
    #10 pop_reset = 1'b0;

    // The whole depth comes back as credit, then nothing more
    wait_credits(fifo_depth, 200);
    repeat (30) @(negedge push_clk);
    check_value("sender credits", fifo_depth, credits_held);
    check_value("credit_count_push", 0, credit_count_push);

    // Random traffic with random stall
    sender_on    = 1'b1;
    stall_random = 1'b1;
    repeat (1500) @(negedge push_clk);

    // Same traffic while part of the credit is reserved
    withhold_target = 1 + $urandom_range(fifo_depth - 2);
    repeat (1500) @(negedge push_clk);
    drain_and_check(withhold_target);

    // Reserve released; traffic without stall
    withhold_target = 0;
    sender_on       = 1'b1;
    repeat (1000) @(negedge push_clk);
    drain_and_check(0);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/fifo_ptr_pkg.sv
hdl/fifo_flow_pkg.sv
hdl/cdc_gray_count_sync.sv
hdl/cdc_fifo_push_ctrl.sv
hdl/cdc_fifo_pop_ctrl.sv
hdl/cdc_fifo_ctrl.sv
hdl/cdc_fifo_ram.sv
hdl/cdc_fifo.sv
verif/cdc_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: cdc_fifo

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fifo_ptr_pkg.sv
      - hdl/fifo_flow_pkg.sv
      - hdl/cdc_gray_count_sync.sv
      - hdl/cdc_fifo_push_ctrl.sv
      - hdl/cdc_fifo_pop_ctrl.sv
      - hdl/cdc_fifo_ctrl.sv
      - hdl/cdc_fifo_ram.sv
      - hdl/cdc_fifo.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/cdc_fifo_tb.sv
